/* hw/flush_ctrl.sv */
//======================================================================
// flush controller
// fans a flush out to both caches, one done pulse when both finish
//======================================================================

`timescale 1ns/1ns
`default_nettype none

module flush_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic flush,
  output logic flush_req_i,
  output logic flush_req_d,
  input  logic flush_ack_i,
  input  logic flush_ack_d,
  output logic flush_done
);

  logic pend_i_q;
  logic pend_d_q;
  logic busy;
  logic last_ack;

  assign busy = pend_i_q || pend_d_q;

  // every pending side is acked in this cycle
  assign last_ack = busy && (!pend_i_q || flush_ack_i) && (!pend_d_q || flush_ack_d);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pend_i_q    <= 1'b0;
      pend_d_q    <= 1'b0;
      flush_req_i <= 1'b0;
      flush_req_d <= 1'b0;
      flush_done  <= 1'b0;
    end else begin
      flush_req_i <= 1'b0;
      flush_req_d <= 1'b0;
      flush_done  <= last_ack;
      if (!busy) begin
        // new flush only when nothing is pending
        if (flush) begin
          pend_i_q    <= 1'b1;
          pend_d_q    <= 1'b1;
          flush_req_i <= 1'b1;
          flush_req_d <= 1'b1;
        end
      end else begin
        if (flush_ack_i) begin
          pend_i_q <= 1'b0;
        end
        if (flush_ack_d) begin
          pend_d_q <= 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hw/l1_cache.sv */
//======================================================================
// l1 cache
// blocking direct-mapped write-through cache, one word per line,
// with a line-by-line invalidate walker for flush
//======================================================================

`timescale 1ns/1ns
`default_nettype none

`include "l1_cache_cfg.svh"

module l1_cache (
  input  logic        clk,
  input  logic        rst_n,
  mem_port_if.slave   cpu,
  mem_port_if.master  refill,
  input  logic        flush_req,
  output logic        flush_ack
);
  import mem_msgs_pkg::*;

  localparam int unsigned         LINES    = `CACHE_LINES;
  localparam int unsigned         IDX_BITS = `CACHE_IDX_BITS;
  localparam logic [IDX_BITS-1:0] LAST_IDX = IDX_BITS'(LINES - 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_MEM_WAIT,
    ST_RESPOND,
    ST_FLUSH
  } state_e;

  state_e                     state_q;

  // line storage
  logic [LINES-1:0]           valid_q;
  logic [`CACHE_TAG_BITS-1:0] tag_q  [LINES];
  logic [`MEM_DATA_BITS-1:0]  data_q [LINES];

  // request being served and its response
  mem_req_t                   req_q;
  mem_resp_t                  resp_q;
  logic                       req_sent_q;

  // flush bookkeeping
  logic                       flush_pend_q;
  logic [IDX_BITS-1:0]        flush_idx_q;

  cache_addr_u                in_addr;
  cache_addr_u                req_addr;
  logic                       in_hit;
  logic                       in_write;
  logic                       cpu_go;
  logic                       fill_go;

  //====================================================================
  // lookup
  //====================================================================

  assign in_addr.raw  = cpu.req_msg.addr;
  assign req_addr.raw = req_q.addr;

  assign in_hit   = valid_q[in_addr.f.idx] && (tag_q[in_addr.f.idx] == in_addr.f.tag);
  assign in_write = (cpu.req_msg.msg_type == MEM_WRITE);

  // no new request while a flush is waiting or starting
  assign cpu.req_rdy  = (state_q == ST_IDLE) && !flush_pend_q && !flush_req;
  assign cpu.resp_val = (state_q == ST_RESPOND);
  assign cpu.resp_msg = resp_q;

  assign cpu_go  = cpu.req_val && cpu.req_rdy;
  assign fill_go = refill.resp_val && refill.resp_rdy;

  // one memory transaction per miss or write
  assign refill.req_val  = (state_q == ST_MEM_WAIT) && !req_sent_q;
  assign refill.req_msg  = req_q;
  assign refill.resp_rdy = (state_q == ST_MEM_WAIT) && req_sent_q;

  //====================================================================
  // control FSM
  //====================================================================

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q      <= ST_IDLE;
      valid_q      <= '0;
      req_sent_q   <= 1'b0;
      flush_pend_q <= 1'b0;
      flush_idx_q  <= '0;
      flush_ack    <= 1'b0;
    end else begin
      flush_ack <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (flush_req || flush_pend_q) begin
            state_q      <= ST_FLUSH;
            flush_pend_q <= 1'b0;
            flush_idx_q  <= '0;
          end else if (cpu_go) begin
            if (!in_write && in_hit) begin
              state_q <= ST_RESPOND;
            end else begin
              state_q    <= ST_MEM_WAIT;
              req_sent_q <= 1'b0;
            end
          end
        end
        ST_MEM_WAIT: begin
          if (flush_req) begin
            flush_pend_q <= 1'b1;
          end
          if (refill.req_val && refill.req_rdy) begin
            req_sent_q <= 1'b1;
          end
          if (fill_go) begin
            state_q <= ST_RESPOND;
            // no allocate on write miss
            if (req_q.msg_type == MEM_READ) begin
              valid_q[req_addr.f.idx] <= 1'b1;
            end
          end
        end
        ST_RESPOND: begin
          if (flush_req) begin
            flush_pend_q <= 1'b1;
          end
          if (cpu.resp_rdy) begin
            state_q <= ST_IDLE;
          end
        end
        ST_FLUSH: begin
          // invalidate one line per cycle
          valid_q[flush_idx_q] <= 1'b0;
          flush_idx_q          <= flush_idx_q + 1'b1;
          if (flush_idx_q == LAST_IDX) begin
            state_q   <= ST_IDLE;
            flush_ack <= 1'b1;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  //====================================================================
  // datapath
  //====================================================================

  always_ff @(posedge clk) begin
    if (cpu_go) begin
      req_q           <= cpu.req_msg;
      resp_q.msg_type <= cpu.req_msg.msg_type;
      resp_q.opaque   <= cpu.req_msg.opaque;
      resp_q.data     <= in_write ? '0 : data_q[in_addr.f.idx];
      // write hit keeps the line in step with memory
      if (in_write && in_hit) begin
        data_q[in_addr.f.idx] <= cpu.req_msg.data;
      end
    end
    if (fill_go && (req_q.msg_type == MEM_READ)) begin
      tag_q[req_addr.f.idx]  <= req_addr.f.tag;
      data_q[req_addr.f.idx] <= refill.resp_msg.data;
      resp_q.data            <= refill.resp_msg.data;
    end
  end

endmodule

`default_nettype wire

/* hw/l1_cache_cfg.svh */
//======================================================================
// l1 cache configuration
// cache geometry and memory message field widths
//======================================================================

`ifndef L1_CACHE_CFG_SVH
`define L1_CACHE_CFG_SVH

// message field widths
`define MEM_ADDR_BITS   32
`define MEM_DATA_BITS   32
`define MEM_OPAQUE_BITS 8

// direct-mapped, one 32-bit word per line
`define CACHE_LINES     16
`define CACHE_IDX_BITS  4
`define CACHE_OFF_BITS  2
`define CACHE_TAG_BITS  (`MEM_ADDR_BITS - `CACHE_IDX_BITS - `CACHE_OFF_BITS)

`endif

/* hw/l1_mem_top.sv */
//======================================================================
// l1 memory subsystem top
// split instruction/data caches sharing one memory port
//======================================================================

`timescale 1ns/1ns
`default_nettype none

module l1_mem_top (
  input  logic                   clk,
  input  logic                   rst_n,

  // instruction port
  input  logic                   imem_req_val,
  output logic                   imem_req_rdy,
  input  mem_msgs_pkg::mem_req_t  imem_req_msg,
  output logic                   imem_resp_val,
  input  logic                   imem_resp_rdy,
  output mem_msgs_pkg::mem_resp_t imem_resp_msg,

  // data port
  input  logic                   dmem_req_val,
  output logic                   dmem_req_rdy,
  input  mem_msgs_pkg::mem_req_t  dmem_req_msg,
  output logic                   dmem_resp_val,
  input  logic                   dmem_resp_rdy,
  output mem_msgs_pkg::mem_resp_t dmem_resp_msg,

  // shared memory
  output logic                   mem_req_val,
  input  logic                   mem_req_rdy,
  output mem_msgs_pkg::mem_req_t  mem_req_msg,
  input  logic                   mem_resp_val,
  output logic                   mem_resp_rdy,
  input  mem_msgs_pkg::mem_resp_t mem_resp_msg,

  input  logic                   flush,
  output logic                   flush_done
);

  mem_port_if cpu_i_port ();
  mem_port_if cpu_d_port ();
  mem_port_if refill_i ();
  mem_port_if refill_d ();
  mem_port_if mem_bus ();

  logic flush_req_i;
  logic flush_req_d;
  logic flush_ack_i;
  logic flush_ack_d;

  //====================================================================
  // plain ports onto the interfaces
  //====================================================================

  assign cpu_i_port.req_val  = imem_req_val;
  assign cpu_i_port.req_msg  = imem_req_msg;
  assign cpu_i_port.resp_rdy = imem_resp_rdy;
  assign imem_req_rdy        = cpu_i_port.req_rdy;
  assign imem_resp_val       = cpu_i_port.resp_val;
  assign imem_resp_msg       = cpu_i_port.resp_msg;

  assign cpu_d_port.req_val  = dmem_req_val;
  assign cpu_d_port.req_msg  = dmem_req_msg;
  assign cpu_d_port.resp_rdy = dmem_resp_rdy;
  assign dmem_req_rdy        = cpu_d_port.req_rdy;
  assign dmem_resp_val       = cpu_d_port.resp_val;
  assign dmem_resp_msg       = cpu_d_port.resp_msg;

  assign mem_req_val          = mem_bus.req_val;
  assign mem_req_msg          = mem_bus.req_msg;
  assign mem_resp_rdy         = mem_bus.resp_rdy;
  assign mem_bus.req_rdy      = mem_req_rdy;
  assign mem_bus.resp_val     = mem_resp_val;
  assign mem_bus.resp_msg     = mem_resp_msg;

  flush_ctrl flush0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush       (flush),
    .flush_req_i (flush_req_i),
    .flush_req_d (flush_req_d),
    .flush_ack_i (flush_ack_i),
    .flush_ack_d (flush_ack_d),
    .flush_done  (flush_done)
  );

  l1_cache icache (
    .clk       (clk),
    .rst_n     (rst_n),
    .cpu       (cpu_i_port.slave),
    .refill    (refill_i.master),
    .flush_req (flush_req_i),
    .flush_ack (flush_ack_i)
  );

  l1_cache dcache (
    .clk       (clk),
    .rst_n     (rst_n),
    .cpu       (cpu_d_port.slave),
    .refill    (refill_d.master),
    .flush_req (flush_req_d),
    .flush_ack (flush_ack_d)
  );

  mem_arbiter arb0 (
    .clk    (clk),
    .rst_n  (rst_n),
    .port_i (refill_i.slave),
    .port_d (refill_d.slave),
    .mem    (mem_bus.master)
  );

endmodule

`default_nettype wire

/* hw/mem_arbiter.sv */
//======================================================================
// memory arbiter
// round-robin merge of two cache ports onto one memory port,
// one transaction in flight at a time
//======================================================================

`timescale 1ns/1ns
`default_nettype none

module mem_arbiter (
  input  logic        clk,
  input  logic        rst_n,
  mem_port_if.slave   port_i,
  mem_port_if.slave   port_d,
  mem_port_if.master  mem
);
  import mem_msgs_pkg::*;

  // owner_q is 1 for the data side, and doubles as last winner
  logic busy_q;
  logic sent_q;
  logic owner_q;
  logic sel;
  logic cur;

  // round-robin pick while idle
  always_comb begin
    if (port_i.req_val && port_d.req_val) begin
      sel = ~owner_q;
    end else begin
      sel = port_d.req_val;
    end
  end

  assign cur = busy_q ? owner_q : sel;

  //====================================================================
  // request steering
  //====================================================================

  always_comb begin
    if (busy_q) begin
      mem.req_val = !sent_q && (owner_q ? port_d.req_val : port_i.req_val);
    end else begin
      mem.req_val = port_i.req_val || port_d.req_val;
    end
  end

  assign mem.req_msg = cur ? port_d.req_msg : port_i.req_msg;

  assign port_i.req_rdy = mem.req_rdy && !cur && !(busy_q && sent_q);
  assign port_d.req_rdy = mem.req_rdy &&  cur && !(busy_q && sent_q);

  //====================================================================
  // response steering, back to the owner only
  //====================================================================

  assign port_i.resp_val = busy_q && !owner_q && mem.resp_val;
  assign port_d.resp_val = busy_q &&  owner_q && mem.resp_val;
  assign port_i.resp_msg = mem.resp_msg;
  assign port_d.resp_msg = mem.resp_msg;

  assign mem.resp_rdy = busy_q && (owner_q ? port_d.resp_rdy : port_i.resp_rdy);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy_q  <= 1'b0;
      sent_q  <= 1'b0;
      owner_q <= 1'b1;
    end else if (!busy_q) begin
      if (mem.req_val) begin
        busy_q  <= 1'b1;
        owner_q <= sel;
        sent_q  <= mem.req_rdy;
      end
    end else begin
      if (mem.req_val && mem.req_rdy) begin
        sent_q <= 1'b1;
      end
      // release only after the response is taken
      if (mem.resp_val && mem.resp_rdy) begin
        busy_q <= 1'b0;
        sent_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/mem_msgs_pkg.sv */
//======================================================================
// memory message types
// request/response messages and the cache address view
//======================================================================

`default_nettype none

`include "l1_cache_cfg.svh"

package mem_msgs_pkg;

  typedef enum logic [0:0] {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_type_e;

  // msg_type carries the read/write kind
  typedef struct packed {
    mem_type_e                    msg_type;
    logic [`MEM_OPAQUE_BITS-1:0]  opaque;
    logic [`MEM_ADDR_BITS-1:0]    addr;
    logic [`MEM_DATA_BITS-1:0]    data;
  } mem_req_t;

  // data is zero on a write ack
  typedef struct packed {
    mem_type_e                    msg_type;
    logic [`MEM_OPAQUE_BITS-1:0]  opaque;
    logic [`MEM_DATA_BITS-1:0]    data;
  } mem_resp_t;

  // same address word, raw or split into tag / idx / off
  typedef union packed {
    logic [`MEM_ADDR_BITS-1:0] raw;
    struct packed {
      logic [`CACHE_TAG_BITS-1:0] tag;
      logic [`CACHE_IDX_BITS-1:0] idx;
      logic [`CACHE_OFF_BITS-1:0] off;
    } f;
  } cache_addr_u;

endpackage

`default_nettype wire

/* hw/mem_port_if.sv */
//======================================================================
// memory port interface
// val/rdy request channel plus val/rdy response channel
//======================================================================

`timescale 1ns/1ns
`default_nettype none

interface mem_port_if ();
  import mem_msgs_pkg::*;

  // request channel
  logic      req_val;
  logic      req_rdy;
  mem_req_t  req_msg;

  // response channel
  logic      resp_val;
  logic      resp_rdy;
  mem_resp_t resp_msg;

  // requester side
  modport master (
    output req_val, req_msg, resp_rdy,
    input  req_rdy, resp_val, resp_msg
  );

  // responder side
  modport slave (
    input  req_val, req_msg, resp_rdy,
    output req_rdy, resp_val, resp_msg
  );

endinterface

`default_nettype wire

/* l1_mem_top.f */
+incdir+hw
hw/mem_msgs_pkg.sv
hw/mem_port_if.sv
hw/flush_ctrl.sv
hw/l1_cache.sv
hw/mem_arbiter.sv
hw/l1_mem_top.sv
sim/tb_mem_model.sv
sim/tb_l1_mem.sv

/* run_sim.sh */
#!/bin/sh
# build and run the l1 memory subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_l1_mem -f l1_mem_top.f

out="$(./obj_dir/Vtb_l1_mem)"
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Test OK"; then
  exit 0
fi
exit 1

/* sim/tb_l1_mem.sv */
//======================================================================
// l1 memory subsystem testbench
// misses, hits, write-through, concurrent misses, flush, back-pressure
//======================================================================

`timescale 1ns/1ns
`default_nettype none

module tb_l1_mem;
  import mem_msgs_pkg::*;

  // 6 tests x up to 40 accesses x ~12 cycles, plus flush walks, with margin
  localparam int          TIMEOUT_CYCLES = 4000;
  localparam bit          PORT_I = 1'b0;
  localparam bit          PORT_D = 1'b1;
  localparam logic [31:0] I_BASE = 32'h0000_1000;
  localparam logic [31:0] D_BASE = 32'h0000_2000;

  logic      clk;
  logic      rst_n;
  logic      imem_req_val, imem_req_rdy, imem_resp_val, imem_resp_rdy;
  mem_req_t  imem_req_msg;
  mem_resp_t imem_resp_msg;
  logic      dmem_req_val, dmem_req_rdy, dmem_resp_val, dmem_resp_rdy;
  mem_req_t  dmem_req_msg;
  mem_resp_t dmem_resp_msg;
  logic      mem_req_val, mem_req_rdy, mem_resp_val, mem_resp_rdy;
  mem_req_t  mem_req_msg;
  mem_resp_t mem_resp_msg;
  logic      flush, flush_done, stall;

  // expected responses per port, in issue order
  mem_resp_t   exp_i_q[$];
  mem_resp_t   exp_d_q[$];
  string       name_i_q[$];
  string       name_d_q[$];
  logic [31:0] shadow [logic [31:0]];

  logic [7:0] opaque_ctr = 8'h00;
  int issued_i = 0, issued_d = 0, resp_i_cnt = 0, resp_d_cnt = 0;
  int mem_req_cnt = 0, flush_done_cnt = 0, cycles = 0;
  int fails = 0, fails_at_start = 0, tests_passed = 0, tests_failed = 0;
  string test_name;

  l1_mem_top dut0 (.*);

  tb_mem_model mem0 (
    .clk (clk), .rst_n (rst_n), .stall (stall),
    .mem_req_val (mem_req_val), .mem_req_rdy (mem_req_rdy), .mem_req_msg (mem_req_msg),
    .mem_resp_val (mem_resp_val), .mem_resp_rdy (mem_resp_rdy),
    .mem_resp_msg (mem_resp_msg)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  //====================================================================
  // reference model
  //====================================================================

  function automatic logic [31:0] mem_init_word(input logic [31:0] addr);
    return addr ^ 32'hc0de_0000;
  endfunction

  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    return shadow.exists(addr) ? shadow[addr] : mem_init_word(addr);
  endfunction

  // same idx, next tag
  function automatic logic [31:0] alias_of(input logic [31:0] addr);
    cache_addr_u a;
    a.raw   = addr;
    a.f.tag = a.f.tag + 1'b1;
    return a.raw;
  endfunction

  task automatic check_resp(input string name, input mem_resp_t exp, input mem_resp_t act);
    if (act !== exp) begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      fails++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("FAIL %s expected %0d actual %0d", name, exp, act);
      fails++;
    end
  endtask

  //====================================================================
  // stimulus helpers, all driving on the falling edge
  //====================================================================

  task automatic send_req(input bit port_d, input bit is_write,
                          input logic [31:0] addr, input logic [31:0] data);
    mem_req_t  req;
    mem_resp_t exp;
    string     name;
    req.msg_type = is_write ? MEM_WRITE : MEM_READ;
    req.opaque   = opaque_ctr;
    req.addr     = addr;
    req.data     = is_write ? data : '0;
    opaque_ctr   = opaque_ctr + 8'd1;
    exp.msg_type = req.msg_type;
    exp.opaque   = req.opaque;
    if (is_write) begin
      shadow[addr] = data;
      exp.data     = '0;
      name         = $sformatf("%s write %h", test_name, addr);
    end else begin
      exp.data = expected_word(addr);
      name     = $sformatf("%s read %h", test_name, addr);
    end
    @(negedge clk);
    if (port_d) begin
      exp_d_q.push_back(exp);
      name_d_q.push_back(name);
      dmem_req_msg = req;
      dmem_req_val = 1'b1;
      while (!dmem_req_rdy) @(negedge clk);
      @(negedge clk);
      dmem_req_val = 1'b0;
      issued_d++;
    end else begin
      exp_i_q.push_back(exp);
      name_i_q.push_back(name);
      imem_req_msg = req;
      imem_req_val = 1'b1;
      while (!imem_req_rdy) @(negedge clk);
      @(negedge clk);
      imem_req_val = 1'b0;
      issued_i++;
    end
  endtask

  task automatic wait_idle(input bit port_d);
    if (port_d) begin
      while (resp_d_cnt < issued_d) @(negedge clk);
    end else begin
      while (resp_i_cnt < issued_i) @(negedge clk);
    end
  endtask

  task automatic access(input bit port_d, input bit is_write,
                        input logic [31:0] addr, input logic [31:0] data);
    send_req(port_d, is_write, addr, data);
    wait_idle(port_d);
  endtask

  task automatic begin_test(input string name);
    test_name      = name;
    fails_at_start = fails;
  endtask

  task automatic end_test();
    if (fails == fails_at_start) begin
      $display("test %-16s ok", test_name);
      tests_passed++;
    end else begin
      $display("test %-16s %0d error(s)", test_name, fails - fails_at_start);
      tests_failed++;
    end
  endtask

  //====================================================================
  // compare process, samples in the low phase
  //====================================================================

  task automatic take_resp(input bit port_d, input mem_resp_t act);
    mem_resp_t exp;
    string     name;
    if ((port_d ? exp_d_q.size() : exp_i_q.size()) == 0) begin
      $display("a response came back with no request outstanding on port %0d", port_d);
      fails++;
    end else begin
      exp  = port_d ? exp_d_q.pop_front() : exp_i_q.pop_front();
      name = port_d ? name_d_q.pop_front() : name_i_q.pop_front();
      check_resp(name, exp, act);
    end
  endtask

  always begin
    @(negedge clk);
    #1;
    if (rst_n) begin
      if (imem_resp_val && imem_resp_rdy) begin
        take_resp(PORT_I, imem_resp_msg);
        resp_i_cnt++;
      end
      if (dmem_resp_val && dmem_resp_rdy) begin
        take_resp(PORT_D, dmem_resp_msg);
        resp_d_cnt++;
      end
      if (mem_req_val && mem_req_rdy) begin
        mem_req_cnt++;
      end
      if (flush_done) begin
        flush_done_cnt++;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("run timed out after %0d cycles, a response never arrived", cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  //====================================================================
  // test sequence
  //====================================================================

  initial begin : run_tests
    int        base_cnt;
    int        taken;
    mem_resp_t held;
    rst_n         = 1'b0;
    imem_req_val  = 1'b0;
    imem_req_msg  = '0;
    imem_resp_rdy = 1'b1;
    dmem_req_val  = 1'b0;
    dmem_req_msg  = '0;
    dmem_resp_rdy = 1'b1;
    flush         = 1'b0;
    stall         = 1'b0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;

    begin_test("read_miss");
    check_count("reset imem_req_rdy", 1, int'(imem_req_rdy));
    check_count("reset dmem_req_rdy", 1, int'(dmem_req_rdy));
    check_count("reset imem_resp_val", 0, int'(imem_resp_val));
    check_count("reset dmem_resp_val", 0, int'(dmem_resp_val));
    check_count("reset mem_req_val", 0, int'(mem_req_val));
    check_count("reset flush_done", 0, int'(flush_done));
    base_cnt = mem_req_cnt;
    for (int k = 0; k < 4; k++) begin
      access(PORT_D, 1'b0, D_BASE + k * 4, '0);
      access(PORT_I, 1'b0, I_BASE + k * 4, '0);
    end
    check_count("read_miss mem requests", 8, mem_req_cnt - base_cnt);
    end_test();

    begin_test("read_hit");
    base_cnt = mem_req_cnt;
    for (int k = 0; k < 4; k++) begin
      access(PORT_D, 1'b0, D_BASE + k * 4, '0);
      access(PORT_I, 1'b0, I_BASE + k * 4, '0);
    end
    check_count("read_hit mem requests", 0, mem_req_cnt - base_cnt);
    end_test();

    // hit write, miss write, then an alias on idx 0
    begin_test("write_through");
    base_cnt = mem_req_cnt;
    access(PORT_D, 1'b1, D_BASE, 32'h1234_5678);
    access(PORT_D, 1'b1, D_BASE + 32'h10, 32'hcafe_f00d);
    access(PORT_D, 1'b0, D_BASE, '0);
    access(PORT_D, 1'b0, D_BASE + 32'h10, '0);
    access(PORT_D, 1'b1, alias_of(D_BASE), 32'hdead_beef);
    access(PORT_D, 1'b0, D_BASE, '0);
    check_count("write_through mem requests", 4, mem_req_cnt - base_cnt);
    end_test();

    begin_test("concurrent_miss");
    base_cnt = mem_req_cnt;
    stall    = 1'b1;
    fork
      for (int k = 8; k < 12; k++) access(PORT_I, 1'b0, I_BASE + k * 4, '0);
      for (int k = 8; k < 12; k++) access(PORT_D, 1'b0, D_BASE + k * 4, '0);
    join
    stall = 1'b0;
    check_count("concurrent_miss mem requests", 8, mem_req_cnt - base_cnt);
    end_test();

    begin_test("flush");
    taken = flush_done_cnt;
    @(negedge clk);
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    while (flush_done_cnt == taken) @(negedge clk);
    // quiet window longer than a walk, to catch a second pulse
    repeat (20) @(negedge clk);
    check_count("flush done pulses", 1, flush_done_cnt - taken);
    base_cnt = mem_req_cnt;
    for (int k = 0; k < 4; k++) begin
      access(PORT_D, 1'b0, D_BASE + k * 4, '0);
      access(PORT_I, 1'b0, I_BASE + k * 4, '0);
    end
    check_count("flush refetch mem requests", 8, mem_req_cnt - base_cnt);
    end_test();

    begin_test("back_pressure");
    base_cnt = mem_req_cnt;
    @(negedge clk);
    imem_resp_rdy = 1'b0;
    send_req(PORT_I, 1'b0, I_BASE, '0);
    while (!imem_resp_val) @(negedge clk);
    held = imem_resp_msg;
    repeat (6) begin
      @(negedge clk);
      check_count("back_pressure resp_val held", 1, int'(imem_resp_val));
      check_count("back_pressure req_rdy low", 0, int'(imem_req_rdy));
      check_resp("back_pressure msg stable", held, imem_resp_msg);
    end
    taken         = resp_i_cnt;
    imem_resp_rdy = 1'b1;
    wait_idle(PORT_I);
    // a few more cycles so a repeated response would be counted
    repeat (3) @(negedge clk);
    check_count("back_pressure responses taken", 1, resp_i_cnt - taken);
    check_count("back_pressure resp_val dropped", 0, int'(imem_resp_val));
    check_count("back_pressure mem requests", 0, mem_req_cnt - base_cnt);
    end_test();

    $display("summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
    if (tests_failed == 0 && fails == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim/tb_mem_model.sv */
//======================================================================
// behavioral memory model
// answers the shared memory port one cycle after each request
//======================================================================

`timescale 1ns/1ns
`default_nettype none

module tb_mem_model (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    stall,
  input  logic                    mem_req_val,
  output logic                    mem_req_rdy,
  input  mem_msgs_pkg::mem_req_t  mem_req_msg,
  output logic                    mem_resp_val,
  input  logic                    mem_resp_rdy,
  output mem_msgs_pkg::mem_resp_t mem_resp_msg
);
  import mem_msgs_pkg::*;

  // sparse storage, only written words are kept
  logic [31:0] words [logic [31:0]];
  int          stall_left;
  integer      seed;

  // content of a word that was never written
  function automatic logic [31:0] init_word(input logic [31:0] addr);
    return addr ^ 32'hc0de_0000;
  endfunction

  initial seed = 32'h7ba;

  assign mem_req_rdy = !mem_resp_val && (stall_left == 0);

  // random stretches of back-pressure while stall is high
  always @(posedge clk) begin : stall_gen
    int r;
    r = $random(seed);
    if (!rst_n) begin
      stall_left <= 0;
    end else if (stall_left != 0) begin
      stall_left <= stall_left - 1;
    end else if (stall && ((r & 8) != 0)) begin
      stall_left <= 1 + (r & 3);
    end
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      mem_resp_val <= 1'b0;
      mem_resp_msg <= '0;
    end else begin
      if (mem_resp_val && mem_resp_rdy) begin
        mem_resp_val <= 1'b0;
      end
      if (mem_req_val && mem_req_rdy) begin
        mem_resp_val          <= 1'b1;
        mem_resp_msg.msg_type <= mem_req_msg.msg_type;
        mem_resp_msg.opaque   <= mem_req_msg.opaque;
        if (mem_req_msg.msg_type == MEM_WRITE) begin
          words[mem_req_msg.addr] = mem_req_msg.data;
          mem_resp_msg.data <= '0;
        end else if (words.exists(mem_req_msg.addr)) begin
          mem_resp_msg.data <= words[mem_req_msg.addr];
        end else begin
          mem_resp_msg.data <= init_word(mem_req_msg.addr);
        end
      end
    end
  end

endmodule

`default_nettype wire
